// File: Makefile
# verilator flow for the branch target buffer testbench

TOP := tb_bp_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

# the run passes only if the pass line shows up in the simulator output
sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// File: filelist.f
hdl/bp_pkg.sv
hdl/bp_entry_ram.sv
hdl/bp_update_slave.sv
hdl/bp_predict_core.sv
hdl/bp_next_pc.sv
hdl/bp_top.sv
testbench/tb_clk_gen.sv
testbench/tb_bp_top.sv

// File: hdl/bp_entry_ram.sv
/*
 * direct-mapped table generic over its payload type, registered fetch read,
 * registered update read, one write port and a per-entry reset
 */
`timescale 1ns/1ns

module bp_entry_ram #(
  parameter int  NUM_ENTRIES = 64,
  parameter type payload_t   = logic,
  localparam int IDX_W       = $clog2(NUM_ENTRIES)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rd_en,        // fetch read strobe
  input  logic [IDX_W-1:0] rd_idx,
  output payload_t         rd_data,      // valid the cycle after rd_en
  input  logic             rd2_en,       // update read path
  input  logic [IDX_W-1:0] rd2_idx,
  output payload_t         rd2_data,
  input  logic             wr_en,
  input  logic [IDX_W-1:0] wr_idx,
  input  payload_t         wr_data,
  input  payload_t         reset_value   // loaded into every slot on reset
);

  payload_t mem [NUM_ENTRIES];  // table storage

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        mem[i] <= reset_value;  // every slot back to its cold value
      end
    end else if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // reads see the old value when a write hits the same slot on the same edge
  always_ff @(posedge clk) begin
    if (rd_en) rd_data <= mem[rd_idx];
    if (rd2_en) rd2_data <= mem[rd2_idx];
  end

  a_wr_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_idx));

endmodule

// File: hdl/bp_next_pc.sv
/*
 * output register stage, picks the btb target or pc plus four
 */
`timescale 1ns/1ns

module bp_next_pc (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        look_valid,
  input  bp_pkg::pc_t look_pc,
  input  logic        look_hit,
  input  bp_pkg::pc_t look_target,
  output logic        pred_valid,
  output logic        pred_hit,
  output bp_pkg::pc_t pred_next_pc
);
  import bp_pkg::*;

  pc_t next_pc;  // chosen address for this lookup

  assign next_pc = look_hit ? look_target : look_pc + 32'd4;  // sequential fallback

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pred_valid <= 1'b0;
      pred_hit   <= 1'b0;
    end else begin
      pred_valid <= look_valid;
      pred_hit   <= look_hit;  // core qualifies hit with its own valid
    end
  end

  always_ff @(posedge clk) begin
    if (look_valid) pred_next_pc <= next_pc;  // held between lookups
  end

  a_hit_implies_valid: assert property (@(posedge clk) disable iff (!rst_n)
    pred_hit |-> pred_valid);

endmodule

// File: hdl/bp_pkg.sv
/*
 * shared types for the branch target buffer: pc type, 2-bit direction counter,
 * btb entry layout and the table reset constants
 */
package bp_pkg;

  typedef logic [31:0] pc_t;  // instruction address

  // two-bit direction counter, msb is the predict-taken bit
  typedef enum logic [1:0] {
    CTR_SNT = 2'b00,  // strongly not taken
    CTR_WNT = 2'b01,  // weakly not taken
    CTR_WT  = 2'b10,  // weakly taken
    CTR_ST  = 2'b11   // strongly taken
  } ctr_t;

  // one direct-mapped btb slot, 65 bits
  typedef struct packed {
    logic valid;   // slot holds a branch
    pc_t  src_pc;  // full source pc kept as tag
    pc_t  target;  // last taken target
  } btb_entry_t;

  // values every slot takes on reset
  localparam btb_entry_t ENTRY_RESET = '0;       // invalid, zero tag and target
  localparam ctr_t       CTR_RESET   = CTR_SNT;  // cold slots predict not taken

endpackage

// File: hdl/bp_predict_core.sv
/*
 * predictor core: btb entry and counter tables, tag compare for fetch,
 * saturating-counter and allocation rules for updates
 */
`timescale 1ns/1ns

module bp_predict_core #(
  parameter int  NUM_ENTRIES = 64,
  localparam int IDX_W       = $clog2(NUM_ENTRIES)
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_valid,
  input  bp_pkg::pc_t fetch_pc,
  input  logic        upd_valid,
  input  bp_pkg::pc_t upd_pc,
  input  bp_pkg::pc_t upd_target,
  input  logic        upd_taken,
  output logic        look_valid,   // lookup result ready this cycle
  output bp_pkg::pc_t look_pc,
  output logic        look_hit,
  output bp_pkg::pc_t look_target
);
  import bp_pkg::*;

  logic       f_valid_q;    // fetch request, read on the next edge
  pc_t        f_pc_q;
  logic       l_valid_q;    // read issued, data now on the ram outputs
  pc_t        l_pc_q;
  btb_entry_t ent_rd;       // fetch view of the tables
  ctr_t       ctr_rd;
  logic       u_valid_q;    // update held between read and write-back
  pc_t        u_pc_q;
  pc_t        u_target_q;
  logic       u_taken_q;
  btb_entry_t u_ent;        // update view of the tables
  ctr_t       u_ctr;
  logic       tag_match;
  btb_entry_t ent_next;
  ctr_t       ctr_next;
  logic       wr_en;
  logic signed [2:0] ctr_step;  // counter movement of one update

  function automatic ctr_t ctr_move(ctr_t c, logic up);
    ctr_t r;
    r = c;
    if (up && c != CTR_ST) r = ctr_t'(c + 2'd1);         // saturate at strongly taken
    else if (!up && c != CTR_SNT) r = ctr_t'(c - 2'd1);  // saturate at strongly not taken
    return r;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      f_valid_q <= 1'b0;
      l_valid_q <= 1'b0;
      u_valid_q <= 1'b0;
    end else begin
      f_valid_q <= fetch_valid;
      l_valid_q <= f_valid_q;
      u_valid_q <= upd_valid;
    end
  end

  always_ff @(posedge clk) begin
    f_pc_q     <= fetch_pc;
    l_pc_q     <= f_pc_q;
    u_pc_q     <= upd_pc;
    u_target_q <= upd_target;
    u_taken_q  <= upd_taken;
  end

  bp_entry_ram #(.NUM_ENTRIES(NUM_ENTRIES), .payload_t(btb_entry_t)) entry_ram_i (
    .clk(clk), .rst_n(rst_n),
    .rd_en(f_valid_q), .rd_idx(f_pc_q[IDX_W+1:2]), .rd_data(ent_rd),
    .rd2_en(upd_valid), .rd2_idx(upd_pc[IDX_W+1:2]), .rd2_data(u_ent),
    .wr_en(wr_en), .wr_idx(u_pc_q[IDX_W+1:2]), .wr_data(ent_next),
    .reset_value(ENTRY_RESET)
  );

  bp_entry_ram #(.NUM_ENTRIES(NUM_ENTRIES), .payload_t(ctr_t)) ctr_ram_i (
    .clk(clk), .rst_n(rst_n),
    .rd_en(f_valid_q), .rd_idx(f_pc_q[IDX_W+1:2]), .rd_data(ctr_rd),
    .rd2_en(upd_valid), .rd2_idx(upd_pc[IDX_W+1:2]), .rd2_data(u_ctr),
    .wr_en(wr_en), .wr_idx(u_pc_q[IDX_W+1:2]), .wr_data(ctr_next),
    .reset_value(CTR_RESET)
  );

  // update rules, written back one clock after the read
  assign tag_match = u_ent.valid && (u_ent.src_pc == u_pc_q);
  assign wr_en     = u_valid_q && (tag_match || u_taken_q);  // miss and not taken is dropped

  always_comb begin
    ent_next = u_ent;
    ctr_next = u_ctr;
    if (tag_match) begin
      ctr_next = ctr_move(u_ctr, u_taken_q);
      if (u_taken_q) ent_next.target = u_target_q;  // retarget on taken
    end else begin
      ent_next = '{valid: 1'b1, src_pc: u_pc_q, target: u_target_q};  // allocate
      ctr_next = CTR_WT;
    end
  end

  // hit needs a valid slot, a full tag match and a taken-leaning counter
  assign look_valid  = l_valid_q;
  assign look_pc     = l_pc_q;
  assign look_hit    = l_valid_q && ent_rd.valid && (ent_rd.src_pc == l_pc_q) && ctr_rd[1];
  assign look_target = ent_rd.target;

  assign ctr_step = $signed({1'b0, ctr_next}) - $signed({1'b0, u_ctr});

  // allocation is the only jump, every other update moves one step at most
  a_ctr_one_step: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_en && tag_match) |-> (ctr_step inside {-3'sd1, 3'sd0, 3'sd1}));

endmodule

// File: hdl/bp_top.sv
/*
 * branch target buffer top: wishbone update slave, predictor core
 * and next-pc register stage
 */
`timescale 1ns/1ns

module bp_top #(
  parameter int NUM_ENTRIES = 64  // power of two
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_valid,
  input  bp_pkg::pc_t fetch_pc,
  output logic        pred_valid,
  output logic        pred_hit,
  output bp_pkg::pc_t pred_next_pc,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  bp_pkg::pc_t wb_adr,      // resolved branch pc
  input  bp_pkg::pc_t wb_dat_i,    // resolved target
  input  logic        wb_tgd_i,    // taken
  output logic        wb_ack,
  output logic        wb_err
);
  import bp_pkg::*;

  logic upd_valid;    // slave to core
  pc_t  upd_pc;
  pc_t  upd_target;
  logic upd_taken;
  logic look_valid;   // core to output stage
  pc_t  look_pc;
  logic look_hit;
  pc_t  look_target;

  bp_update_slave update_slave_i (
    .clk(clk), .rst_n(rst_n),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_tgd_i(wb_tgd_i),
    .wb_ack(wb_ack), .wb_err(wb_err),
    .upd_valid(upd_valid), .upd_pc(upd_pc),
    .upd_target(upd_target), .upd_taken(upd_taken)
  );

  bp_predict_core #(.NUM_ENTRIES(NUM_ENTRIES)) predict_core_i (
    .clk(clk), .rst_n(rst_n),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .upd_valid(upd_valid), .upd_pc(upd_pc),
    .upd_target(upd_target), .upd_taken(upd_taken),
    .look_valid(look_valid), .look_pc(look_pc),
    .look_hit(look_hit), .look_target(look_target)
  );

  bp_next_pc next_pc_i (
    .clk(clk), .rst_n(rst_n),
    .look_valid(look_valid), .look_pc(look_pc),
    .look_hit(look_hit), .look_target(look_target),
    .pred_valid(pred_valid), .pred_hit(pred_hit),
    .pred_next_pc(pred_next_pc)
  );

endmodule

// File: hdl/bp_update_slave.sv
/*
 * wishbone classic slave for resolved branches, write cycles become
 * one-cycle update requests and read cycles are answered with err
 */
`timescale 1ns/1ns

module bp_update_slave (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  bp_pkg::pc_t wb_adr,      // branch pc
  input  bp_pkg::pc_t wb_dat_i,    // branch target
  input  logic        wb_tgd_i,    // taken outcome
  output logic        wb_ack,
  output logic        wb_err,
  output logic        upd_valid,   // pulses together with ack
  output bp_pkg::pc_t upd_pc,
  output bp_pkg::pc_t upd_target,
  output logic        upd_taken
);
  import bp_pkg::*;

  logic req;           // new bus cycle seen this clock
  logic ack_q;
  logic err_q;
  pc_t  adr_q;         // captured branch pc
  pc_t  dat_q;         // captured target
  logic tgd_q;         // captured outcome

  // the answer cycle blocks a second answer while stb is still held
  assign req = wb_cyc && wb_stb && !ack_q && !err_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req && wb_we;   // write cycle, one update
      err_q <= req && !wb_we;  // reads are not supported
    end
  end

  always_ff @(posedge clk) begin
    if (req && wb_we) begin
      adr_q <= wb_adr;
      dat_q <= wb_dat_i;
      tgd_q <= wb_tgd_i;
    end
  end

  assign wb_ack     = ack_q;
  assign wb_err     = err_q;
  assign upd_valid  = ack_q;  // update issued in the ack cycle
  assign upd_pc     = adr_q;
  assign upd_target = dat_q;
  assign upd_taken  = tgd_q;

  a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_ack && wb_err));

  // an answer always follows a sampled request by exactly one clock
  a_answer_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack || wb_err) |-> $past(wb_cyc && wb_stb));

endmodule

// File: testbench/tb_bp_top.sv
/*
 * testbench for the branch target buffer: fetch and wishbone stimulus,
 * reference tables, prediction and bus assertions, lfsr and run limit
 */
`timescale 1ns/1ns

module tb_bp_top;
  import bp_pkg::*;

  localparam int NUM_ENTRIES  = 64;
  localparam int NUM_DIRECTED = 40;                            // directed lookups and bus cycles
  localparam int NUM_MIX      = 150;                           // random bus cycles, 3 lookups each
  localparam int NUM_OPS      = NUM_DIRECTED + 4 * NUM_MIX;
  localparam int MAX_CYCLES   = 4 * NUM_OPS + 200;

  logic clk;
  logic rst_n;
  logic fetch_valid = 1'b0;
  pc_t  fetch_pc    = '0;
  logic wb_cyc      = 1'b0;
  logic wb_stb      = 1'b0;
  logic wb_we       = 1'b0;
  pc_t  wb_adr      = '0;
  pc_t  wb_dat_i    = '0;
  logic wb_tgd_i    = 1'b0;
  logic pred_valid;
  logic pred_hit;
  pc_t  pred_next_pc;
  logic wb_ack;
  logic wb_err;
  logic wb_req;                      // bus cycle waiting for its answer

  int   err_count   = 0;
  int   write_count = 0;
  int   ack_count   = 0;
  int   pred_count  = 0;
  int   cycle_count = 0;
  logic [15:0] lfsr_state = 16'd26070;
  pc_t  fetch_q [$];                 // pcs waiting to be issued
  logic exp_valid [4];               // expected results, index 3 is due now
  logic exp_hit [4];
  pc_t  exp_next [4];
  logic m_valid [NUM_ENTRIES];       // reference tables
  pc_t  m_src [NUM_ENTRIES];
  pc_t  m_tgt [NUM_ENTRIES];
  int   m_ctr [NUM_ENTRIES];         // 0 strongly not taken .. 3 strongly taken

  tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  bp_top #(.NUM_ENTRIES(NUM_ENTRIES)) bp_top_i (
    .clk(clk), .rst_n(rst_n),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .pred_valid(pred_valid), .pred_hit(pred_hit), .pred_next_pc(pred_next_pc),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_tgd_i(wb_tgd_i), .wb_ack(wb_ack), .wb_err(wb_err)
  );

  assign wb_req = wb_cyc && wb_stb && !wb_ack && !wb_err;

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;  // taps 16 14 13 11
    return n;
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);  // one step per bit
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic int index_of(pc_t pc);
    return int'((pc >> 2) & (NUM_ENTRIES - 1));  // word index, low bits
  endfunction

  function automatic logic model_hit(pc_t pc);
    int i;
    i = index_of(pc);
    return m_valid[i] && (m_src[i] == pc) && (m_ctr[i] >= 2);
  endfunction

  // saturating counter and allocation rules of the btb
  function automatic void model_update(pc_t pc, pc_t tgt, logic taken);
    int i;
    i = index_of(pc);
    if (m_valid[i] && m_src[i] == pc) begin
      if (taken) begin
        if (m_ctr[i] < 3) m_ctr[i] = m_ctr[i] + 1;
        m_tgt[i] = tgt;                          // retarget
      end else if (m_ctr[i] > 0) begin
        m_ctr[i] = m_ctr[i] - 1;
      end
    end else if (taken) begin
      m_valid[i] = 1'b1;                         // allocate, weakly taken
      m_src[i]   = pc;
      m_tgt[i]   = tgt;
      m_ctr[i]   = 2;
    end
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    err_count++;
    $display("ERR %0t %s exp=%h got=%h", $time, name, exp_v, got_v);
  endtask

  // fetch driver and reference model, updates land before the lookup of the same edge
  always @(posedge clk) begin
    pc_t  pc;
    logic hit;
    if (!rst_n) begin
      fetch_valid <= 1'b0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
        m_src[i]   = '0;
        m_tgt[i]   = '0;
        m_ctr[i]   = 0;
      end
      for (int s = 0; s < 4; s++) begin
        exp_valid[s] <= 1'b0;
        exp_hit[s]   <= 1'b0;
        exp_next[s]  <= '0;
      end
    end else begin
      if (wb_ack) begin
        model_update(wb_adr, wb_dat_i, wb_tgd_i);
        ack_count++;
      end
      if (pred_valid) pred_count++;
      for (int s = 3; s > 0; s--) begin
        exp_valid[s] <= exp_valid[s-1];
        exp_hit[s]   <= exp_hit[s-1];
        exp_next[s]  <= exp_next[s-1];
      end
      if (fetch_q.size() != 0) begin
        pc  = fetch_q.pop_front();
        hit = model_hit(pc);
        fetch_valid  <= 1'b1;
        fetch_pc     <= pc;
        exp_valid[0] <= 1'b1;
        exp_hit[0]   <= hit;
        exp_next[0]  <= hit ? m_tgt[index_of(pc)] : pc + 32'd4;
      end else begin
        fetch_valid  <= 1'b0;
        exp_valid[0] <= 1'b0;
        exp_hit[0]   <= 1'b0;
      end
    end
  end

  a_pred_valid: assert property (@(posedge clk) disable iff (!rst_n)
    pred_valid == exp_valid[3])
    else report_mismatch("pred_valid", 32'($sampled(exp_valid[3])), 32'($sampled(pred_valid)));

  a_pred_hit: assert property (@(posedge clk) disable iff (!rst_n)
    pred_hit == (exp_valid[3] && exp_hit[3]))
    else report_mismatch("pred_hit", 32'($sampled(exp_hit[3])), 32'($sampled(pred_hit)));

  a_pred_next_pc: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid[3] |-> (pred_next_pc == exp_next[3]))
    else report_mismatch("pred_next_pc", $sampled(exp_next[3]), $sampled(pred_next_pc));

  a_write_acked: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req && wb_we) |=> (wb_ack && !wb_err))
    else begin
      err_count++;
      $display("%0t: write cycle was not answered by ack one cycle later", $time);
    end

  a_read_errs: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req && !wb_we) |=> (wb_err && !wb_ack))
    else begin
      err_count++;
      $display("%0t: read cycle was not answered by err alone one cycle later", $time);
    end

  a_answer_once: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack || wb_err) |=> !(wb_ack || wb_err))
    else begin
      err_count++;
      $display("%0t: bus answer lasted longer than one cycle", $time);
    end

  a_no_stray_answer: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack || wb_err) |-> $past(wb_req))
    else begin
      err_count++;
      $display("%0t: ack or err appeared without a pending bus cycle", $time);
    end

  // one classic cycle, held until the answer
  task automatic wb_cycle(input logic we, input pc_t adr, input pc_t dat, input logic taken);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_i <= dat;
    wb_tgd_i <= taken;
    @(posedge clk);
    while (!(wb_ack || wb_err)) @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (we) write_count++;
  endtask

  task automatic wb_write(input pc_t pc, input pc_t tgt, input logic taken);
    wb_cycle(1'b1, pc, tgt, taken);
  endtask

  task automatic wb_read(input pc_t pc);
    wb_cycle(1'b0, pc, 32'h0, 1'b0);
  endtask

  task automatic drain();
    while (fetch_q.size() != 0 || exp_valid[0] || exp_valid[1] || exp_valid[2] || exp_valid[3])
      @(posedge clk);
  endtask

  function automatic pc_t rand_pc();
    return 32'h0000_4000 + (take_bits(7) << 2);  // 128 words over 64 slots, aliasing
  endfunction

  initial begin
    pc_t  p;
    pc_t  t;
    pc_t  q;
    logic taken;
    wait (rst_n);
    @(posedge clk);
    for (int i = 0; i < 16; i++) fetch_q.push_back(32'h0000_1000 + 32'(4 * i));  // cold
    drain();
    p = 32'h0000_2040;
    t = 32'h0000_8000;
    wb_write(p, t, 1'b1);          // allocate
    fetch_q.push_back(p);
    fetch_q.push_back(p + 32'd4);
    drain();
    wb_write(p, t, 1'b0);          // down to weakly not taken
    fetch_q.push_back(p);
    drain();
    wb_write(p, t + 32'h40, 1'b1);
    wb_write(p, t + 32'h80, 1'b1); // strongly taken
    wb_write(p, t + 32'h80, 1'b1); // stays saturated
    wb_write(p, t, 1'b0);
    fetch_q.push_back(p);
    drain();
    q = 32'h0000_3000;
    wb_write(q, t, 1'b0);          // unallocated and not taken
    fetch_q.push_back(q);
    wb_write(p + 32'(4 * NUM_ENTRIES), 32'h0000_9000, 1'b1);  // same slot, new tag
    fetch_q.push_back(p);
    fetch_q.push_back(p + 32'(4 * NUM_ENTRIES));
    drain();
    wb_read(p + 32'(4 * NUM_ENTRIES));
    fetch_q.push_back(p + 32'(4 * NUM_ENTRIES));
    fetch_q.push_back(p);
    drain();
    for (int i = 0; i < NUM_MIX; i++) begin
      for (int k = 0; k < 3; k++) fetch_q.push_back(rand_pc());
      p     = rand_pc();
      t     = 32'h0001_0000 + (take_bits(10) << 2);
      taken = (take_bits(2) != 32'd0);  // mostly taken
      if (take_bits(3) == 32'd0) wb_read(p);
      else wb_write(p, t, taken);
    end
    drain();
    a_ack_count: assert (ack_count == write_count)
      else begin
        err_count++;
        $display("%0d writes were issued but %0d acks were seen", write_count, ack_count);
      end
    $display("done: %0d predictions, %0d writes, %0d errors", pred_count, write_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, %0d errors so far", cycle_count, err_count);
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule

// File: testbench/tb_clk_gen.sv
/*
 * clock and reset source for the testbench, 8 ns clock, reset low for two cycles
 */
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;  // released on the third rising edge
  end

endmodule
